/* design/pu_pkg.sv */
package pu_pkg;

  // **********************************************************************
  // Data and attribute types.
  // **********************************************************************

  localparam int DATA_W = 32;

  typedef logic [DATA_W-1:0] data_t;

  // Attribute word carried by every result.
  typedef logic [1:0] attr_t;

  localparam int ATTR_INVALID  = 0;
  localparam int ATTR_OVERFLOW = 1;

  // **********************************************************************
  // Register map.
  // **********************************************************************

  typedef logic [7:0] addr_t;

  localparam addr_t OFF_MULT_A    = 8'h00; // Read returns the product.
  localparam addr_t OFF_MULT_B    = 8'h04;
  localparam addr_t OFF_ADD_A     = 8'h08; // Read returns the sum.
  localparam addr_t OFF_ADD_B     = 8'h0C;
  localparam addr_t OFF_MULT_ATTR = 8'h10;
  localparam addr_t OFF_ADD_ATTR  = 8'h14;

  // Added to an operand offset to store that operand marked invalid.
  localparam addr_t MARK_INVALID  = 8'h20;

endpackage

/* design/pu_mult.sv */
`timescale 1ns/1ps

module pu_mult #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  signal_wr,
  input  logic                  signal_sel,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  attr_in,

  input  logic                  signal_oe,
  input  logic                  attr_oe,
  output logic [DATA_WIDTH-1:0] data_out
);

  localparam int HALF   = DATA_WIDTH / 2;
  localparam int ATTR_W = $bits(pu_pkg::attr_t);

  // Operand A at index 0, operand B at index 1.
  logic [DATA_WIDTH-1:0]   op_q [0:1];
  logic                    op_invalid_q [0:1];

  logic signed [HALF-1:0]       a_low;
  logic signed [HALF-1:0]       b_low;
  logic signed [DATA_WIDTH-1:0] product;
  logic                         invalid;

  logic                  arm_q;
  logic [DATA_WIDTH-1:0] result_q;
  pu_pkg::attr_t         attr_q;

  // Upper half plus the sign bit of the low half must be a pure sign extension.
  function automatic logic fits_half(logic [DATA_WIDTH-1:0] value);
    logic [DATA_WIDTH-HALF:0] upper;
    upper = value[DATA_WIDTH-1:HALF-1];
    return (&upper) || !(|upper);
  endfunction

  // **********************************************************************
  // Operand stage.
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (signal_wr) begin
      op_q[signal_sel]         <= data_in;
      op_invalid_q[signal_sel] <= attr_in;
    end
  end

  assign a_low   = op_q[0][HALF-1:0];
  assign b_low   = op_q[1][HALF-1:0];
  assign product = a_low * b_low; // Signed, widened to the full word.

  assign invalid = !fits_half(op_q[0]) || !fits_half(op_q[1])
                   || op_invalid_q[0] || op_invalid_q[1];

  // **********************************************************************
  // Result stage.
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      arm_q    <= 1'b0;
      result_q <= '0;
      attr_q   <= '0;
    end else begin
      arm_q <= signal_wr && signal_sel; // A write to B starts a new result.
      if (arm_q) begin
        result_q                      <= product;
        attr_q[pu_pkg::ATTR_INVALID]  <= invalid;
        attr_q[pu_pkg::ATTR_OVERFLOW] <= 1'b0;
      end
    end
  end

  // Zero while disabled so the port can OR the units together.
  always_comb begin
    if (!signal_oe) begin
      data_out = '0;
    end else if (attr_oe) begin
      data_out = {{(DATA_WIDTH-ATTR_W){1'b0}}, attr_q};
    end else begin
      data_out = result_q;
    end
  end

endmodule

/* design/pu_add.sv */
`timescale 1ns/1ps

module pu_add #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  signal_wr,
  input  logic                  signal_sel,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  attr_in,

  input  logic                  signal_oe,
  input  logic                  attr_oe,
  output logic [DATA_WIDTH-1:0] data_out
);

  localparam int ATTR_W = $bits(pu_pkg::attr_t);

  logic [DATA_WIDTH-1:0] op_a_q;
  logic [DATA_WIDTH-1:0] op_b_q;
  logic                  op_a_invalid_q;
  logic                  op_b_invalid_q;

  logic [DATA_WIDTH-1:0] sum;
  logic                  overflow;

  logic                  arm_q;
  logic [DATA_WIDTH-1:0] result_q;
  pu_pkg::attr_t         attr_q;

  // **********************************************************************
  // Operand stage.
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (signal_wr && !signal_sel) begin
      op_a_q         <= data_in;
      op_a_invalid_q <= attr_in;
    end
    if (signal_wr && signal_sel) begin
      op_b_q         <= data_in;
      op_b_invalid_q <= attr_in;
    end
  end

  assign sum = op_a_q + op_b_q; // Wraps at the word width.

  // Same operand signs and a different sum sign.
  assign overflow = (op_a_q[DATA_WIDTH-1] == op_b_q[DATA_WIDTH-1])
                    && (sum[DATA_WIDTH-1] != op_a_q[DATA_WIDTH-1]);

  // **********************************************************************
  // Result stage.
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      arm_q    <= 1'b0;
      result_q <= '0;
      attr_q   <= '0;
    end else begin
      arm_q <= signal_wr && signal_sel;
      if (arm_q) begin
        result_q                      <= sum;
        attr_q[pu_pkg::ATTR_INVALID]  <= op_a_invalid_q || op_b_invalid_q;
        attr_q[pu_pkg::ATTR_OVERFLOW] <= overflow;
      end
    end
  end

  always_comb begin
    if (!signal_oe) begin
      data_out = '0;
    end else if (attr_oe) begin
      data_out = {{(DATA_WIDTH-ATTR_W){1'b0}}, attr_q};
    end else begin
      data_out = result_q;
    end
  end

endmodule

/* design/pu_axil_port.sv */
`timescale 1ns/1ps

module pu_axil_port #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,

  input  pu_pkg::addr_t         awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,

  input  pu_pkg::addr_t         araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,

  output logic [DATA_WIDTH-1:0] unit_data,

  output logic                  mult_wr,
  output logic                  mult_sel,
  output logic                  mult_invalid,
  output logic                  mult_oe,
  output logic                  mult_attr_oe,
  input  logic [DATA_WIDTH-1:0] mult_data,

  output logic                  add_wr,
  output logic                  add_sel,
  output logic                  add_invalid,
  output logic                  add_oe,
  output logic                  add_attr_oe,
  input  logic [DATA_WIDTH-1:0] add_data
);

  typedef enum logic [1:0] {WR_IDLE, WR_STROBE, WR_RESPOND} wr_phase_t;
  typedef enum logic [1:0] {RD_IDLE, RD_DRIVE, RD_RESPOND} rd_phase_t;

  wr_phase_t wr_phase;
  rd_phase_t rd_phase;

  pu_pkg::addr_t wr_offset;
  logic          wr_marked;
  logic          wr_hit_mult;
  logic          wr_hit_add;
  logic          wr_hit_b;
  logic          wr_sel_q;
  logic          wr_marked_q;

  logic rd_hit_mult;
  logic rd_hit_add;
  logic rd_hit_attr;
  logic rd_mult_q;
  logic rd_add_q;
  logic rd_attr_q;

  logic [DATA_WIDTH-1:0] mult_q;
  logic [DATA_WIDTH-1:0] add_q;

  // **********************************************************************
  // Write path.
  // **********************************************************************

  assign wr_offset   = awaddr & ~pu_pkg::MARK_INVALID;
  assign wr_marked   = |(awaddr & pu_pkg::MARK_INVALID);
  assign wr_hit_mult = (wr_offset == pu_pkg::OFF_MULT_A) || (wr_offset == pu_pkg::OFF_MULT_B);
  assign wr_hit_add  = (wr_offset == pu_pkg::OFF_ADD_A) || (wr_offset == pu_pkg::OFF_ADD_B);
  assign wr_hit_b    = (wr_offset == pu_pkg::OFF_MULT_B) || (wr_offset == pu_pkg::OFF_ADD_B);

  // Address and data are taken together, only with no response pending.
  assign awready = (wr_phase == WR_IDLE) && awvalid && wvalid;
  assign wready  = awready;
  assign bvalid  = (wr_phase != WR_IDLE);
  assign bresp   = 2'b00; // OKAY.

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_phase <= WR_IDLE;
      mult_wr  <= 1'b0;
      add_wr   <= 1'b0;
    end else begin
      mult_wr <= awready && wr_hit_mult;
      add_wr  <= awready && wr_hit_add;
      case (wr_phase)
        WR_IDLE:    if (awready) wr_phase <= WR_STROBE;
        WR_STROBE:  wr_phase <= bready ? WR_IDLE : WR_RESPOND;
        WR_RESPOND: if (bready) wr_phase <= WR_IDLE;
        default:    wr_phase <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (awready) begin
      wr_sel_q    <= wr_hit_b;
      wr_marked_q <= wr_marked;
      unit_data   <= wdata;
    end
  end

  assign mult_sel     = wr_sel_q;
  assign add_sel      = wr_sel_q;
  assign mult_invalid = wr_marked_q;
  assign add_invalid  = wr_marked_q;

  // **********************************************************************
  // Read path.
  // **********************************************************************

  assign rd_hit_mult = (araddr == pu_pkg::OFF_MULT_A) || (araddr == pu_pkg::OFF_MULT_ATTR);
  assign rd_hit_add  = (araddr == pu_pkg::OFF_ADD_A) || (araddr == pu_pkg::OFF_ADD_ATTR);
  assign rd_hit_attr = (araddr == pu_pkg::OFF_MULT_ATTR) || (araddr == pu_pkg::OFF_ADD_ATTR);

  // A pending write, or one offered this cycle, keeps reads out.
  assign arready = arvalid && (wr_phase == WR_IDLE) && (rd_phase == RD_IDLE)
                   && !(awvalid && wvalid);

  assign mult_oe      = (rd_phase == RD_DRIVE) && rd_mult_q;
  assign add_oe       = (rd_phase == RD_DRIVE) && rd_add_q;
  assign mult_attr_oe = rd_attr_q;
  assign add_attr_oe  = rd_attr_q;
  assign rresp        = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_phase <= RD_IDLE;
      rvalid   <= 1'b0;
    end else begin
      case (rd_phase)
        RD_IDLE:  if (arready) rd_phase <= RD_DRIVE;
        RD_DRIVE: rd_phase <= RD_RESPOND;
        RD_RESPOND: begin
          if (!rvalid) begin
            rvalid <= 1'b1; // Data captured last cycle is now presented.
          end else if (rready) begin
            rvalid   <= 1'b0;
            rd_phase <= RD_IDLE;
          end
        end
        default: rd_phase <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (arready) begin
      rd_mult_q <= rd_hit_mult;
      rd_add_q  <= rd_hit_add;
      rd_attr_q <= rd_hit_attr;
    end
    if (rd_phase == RD_DRIVE) begin
      mult_q <= mult_data;
      add_q  <= add_data;
    end
    if (rd_phase == RD_RESPOND && !rvalid) begin
      rdata <= mult_q | add_q; // Disabled units read as zero.
    end
  end

endmodule

/* design/pu_top.sv */
`timescale 1ns/1ps

module pu_top #(
  parameter int DATA_WIDTH = pu_pkg::DATA_W
) (
  input  logic                  clk,
  input  logic                  rst,

  input  pu_pkg::addr_t         awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,

  input  pu_pkg::addr_t         araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  logic [DATA_WIDTH-1:0] unit_data;

  logic                  mult_wr;
  logic                  mult_sel;
  logic                  mult_invalid;
  logic                  mult_oe;
  logic                  mult_attr_oe;
  logic [DATA_WIDTH-1:0] mult_data;

  logic                  add_wr;
  logic                  add_sel;
  logic                  add_invalid;
  logic                  add_oe;
  logic                  add_attr_oe;
  logic [DATA_WIDTH-1:0] add_data;

  // **********************************************************************
  // Bus front end and the two units beside each other.
  // **********************************************************************

  pu_axil_port #(.DATA_WIDTH(DATA_WIDTH)) pu_axil_port_inst (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .unit_data(unit_data),
    .mult_wr(mult_wr), .mult_sel(mult_sel), .mult_invalid(mult_invalid),
    .mult_oe(mult_oe), .mult_attr_oe(mult_attr_oe), .mult_data(mult_data),
    .add_wr(add_wr), .add_sel(add_sel), .add_invalid(add_invalid),
    .add_oe(add_oe), .add_attr_oe(add_attr_oe), .add_data(add_data)
  );

  pu_mult #(.DATA_WIDTH(DATA_WIDTH)) pu_mult_inst (
    .clk(clk), .rst(rst),
    .signal_wr(mult_wr), .signal_sel(mult_sel),
    .data_in(unit_data), .attr_in(mult_invalid),
    .signal_oe(mult_oe), .attr_oe(mult_attr_oe),
    .data_out(mult_data)
  );

  pu_add #(.DATA_WIDTH(DATA_WIDTH)) pu_add_inst (
    .clk(clk), .rst(rst),
    .signal_wr(add_wr), .signal_sel(add_sel),
    .data_in(unit_data), .attr_in(add_invalid),
    .signal_oe(add_oe), .attr_oe(add_attr_oe),
    .data_out(add_data)
  );

endmodule

/* test/pu_checker.sv */
`timescale 1ns/1ps

module pu_checker #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,

  input  pu_pkg::addr_t         awaddr,
  input  logic                  awvalid,
  input  logic                  awready,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  wvalid,
  input  logic                  wready,
  input  logic [1:0]            bresp,
  input  logic                  bvalid,
  input  logic                  bready,

  input  pu_pkg::addr_t         araddr,
  input  logic                  arvalid,
  input  logic                  arready,
  input  logic [DATA_WIDTH-1:0] rdata,
  input  logic [1:0]            rresp,
  input  logic                  rvalid,
  input  logic                  rready,

  output int                    value_errors,
  output int                    protocol_errors,
  output int                    outstanding
);

  localparam int HALF = DATA_WIDTH / 2;

  logic [DATA_WIDTH-1:0] mult_op [0:1];
  logic                  mult_mark [0:1];
  logic [DATA_WIDTH-1:0] add_op [0:1];
  logic                  add_mark [0:1];

  logic [DATA_WIDTH-1:0] mult_res;
  logic [DATA_WIDTH-1:0] add_res;
  pu_pkg::attr_t         mult_attr;
  pu_pkg::attr_t         add_attr;

  logic [DATA_WIDTH-1:0] expect_q [$];
  logic [DATA_WIDTH-1:0] expected;
  int                    wr_pending;
  int                    rd_pending;

  assign outstanding = wr_pending + rd_pending;

  // True when the word is a signed value that a half-width register can hold.
  function automatic logic in_half_range(logic [DATA_WIDTH-1:0] v);
    longint sv;
    sv = longint'($signed(v));
    return (sv >= -(longint'(1) << (HALF-1))) && (sv < (longint'(1) << (HALF-1)));
  endfunction

  function automatic logic [DATA_WIDTH-1:0] half_product(logic [DATA_WIDTH-1:0] a,
                                                         logic [DATA_WIDTH-1:0] b);
    longint p;
    p = longint'($signed(a[HALF-1:0])) * longint'($signed(b[HALF-1:0]));
    return p[DATA_WIDTH-1:0];
  endfunction

  // **********************************************************************
  // Unit models updated on every accepted write.
  // **********************************************************************

  task automatic record_write(pu_pkg::addr_t addr, logic [DATA_WIDTH-1:0] data);
    pu_pkg::addr_t off;
    logic          marked;
    longint        sum;
    off    = addr & ~pu_pkg::MARK_INVALID;
    marked = (addr & pu_pkg::MARK_INVALID) != 0;
    case (off)
      pu_pkg::OFF_MULT_A: begin
        mult_op[0]   = data;
        mult_mark[0] = marked;
      end
      pu_pkg::OFF_MULT_B: begin
        mult_op[1]   = data;
        mult_mark[1] = marked;
        mult_res     = half_product(mult_op[0], mult_op[1]);
        mult_attr    = '0;
        mult_attr[pu_pkg::ATTR_INVALID] = !in_half_range(mult_op[0])
            || !in_half_range(mult_op[1]) || mult_mark[0] || mult_mark[1];
      end
      pu_pkg::OFF_ADD_A: begin
        add_op[0]   = data;
        add_mark[0] = marked;
      end
      pu_pkg::OFF_ADD_B: begin
        add_op[1]   = data;
        add_mark[1] = marked;
        sum         = longint'($signed(add_op[0])) + longint'($signed(add_op[1]));
        add_res     = sum[DATA_WIDTH-1:0];
        add_attr[pu_pkg::ATTR_INVALID]  = add_mark[0] || add_mark[1];
        add_attr[pu_pkg::ATTR_OVERFLOW] = sum != longint'($signed(add_res)); // Out of range.
      end
      default: ;
    endcase
  endtask

  function automatic logic [DATA_WIDTH-1:0] expected_read(pu_pkg::addr_t addr);
    case (addr)
      pu_pkg::OFF_MULT_A:    return mult_res;
      pu_pkg::OFF_ADD_A:     return add_res;
      pu_pkg::OFF_MULT_ATTR: return {{(DATA_WIDTH-2){1'b0}}, mult_attr};
      pu_pkg::OFF_ADD_ATTR:  return {{(DATA_WIDTH-2){1'b0}}, add_attr};
      default:               return '0;
    endcase
  endfunction

  // **********************************************************************
  // Bus monitor.
  // **********************************************************************

  always @(posedge clk) begin
    if (rst) begin
      mult_res   = '0;
      add_res    = '0;
      mult_attr  = '0;
      add_attr   = '0;
      wr_pending = 0;
      rd_pending = 0;
      expect_q.delete();
    end else begin
      if (bvalid && wr_pending == 0) begin
        $display("bvalid is high with no write outstanding at %0t.", $time);
        protocol_errors++;
      end
      if (rvalid && rd_pending == 0) begin
        $display("rvalid is high with no read outstanding at %0t.", $time);
        protocol_errors++;
      end
      if (awready !== wready) begin
        $display("awready and wready differ at %0t.", $time);
        protocol_errors++;
      end
      if (awready && wr_pending > 0) begin
        $display("awready is high while a write response is pending at %0t.", $time);
        protocol_errors++;
      end
      if (arready && (wr_pending > 0 || rd_pending > 0)) begin
        $display("arready is high while a response is pending at %0t.", $time);
        protocol_errors++;
      end
      if (bvalid && bready && wr_pending > 0) begin
        if (bresp !== 2'b00) begin
          $display("FAILED bresp expected 0x0 observed 0x%h", bresp);
          value_errors++;
        end
        wr_pending--;
      end
      if (rvalid && rready && rd_pending > 0) begin
        expected = expect_q.pop_front();
        rd_pending--;
        if (rdata !== expected) begin
          $display("FAILED rdata expected 0x%h observed 0x%h", expected, rdata);
          value_errors++;
        end
        if (rresp !== 2'b00) begin
          $display("FAILED rresp expected 0x0 observed 0x%h", rresp);
          value_errors++;
        end
      end
      if (awvalid && awready && wvalid && wready) begin
        record_write(awaddr, wdata);
        wr_pending++;
      end
      if (arvalid && arready) begin
        expect_q.push_back(expected_read(araddr)); // Result is settled by now.
        rd_pending++;
      end
    end
  end

endmodule

/* test/pu_tb.sv */
`timescale 1ns/1ps

module pu_tb;

  localparam int DATA_WIDTH   = pu_pkg::DATA_W;
  localparam int HALF         = DATA_WIDTH / 2;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_MULT     = 40;
  localparam int NUM_ADD      = 40;
  localparam int NUM_EDGE     = 5;
  localparam int NUM_MIX      = 30;
  localparam int NUM_HOLES    = 8;
  localparam int NUM_TXN      = 4 + 4 * NUM_MULT + 4 * (NUM_ADD + NUM_EDGE)
                                + 8 * NUM_MIX + NUM_HOLES;

  logic                  clk = 1'b0;
  logic                  rst;
  pu_pkg::addr_t         awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  pu_pkg::addr_t         araddr;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_WIDTH-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;

  int value_errors;
  int protocol_errors;
  int outstanding;
  int run_errors;

  always #2 clk = ~clk;

  pu_top #(.DATA_WIDTH(DATA_WIDTH)) pu_top_inst (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  pu_checker #(.DATA_WIDTH(DATA_WIDTH)) pu_checker_inst (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .value_errors(value_errors), .protocol_errors(protocol_errors),
    .outstanding(outstanding)
  );

  // **********************************************************************
  // Bus tasks.
  // **********************************************************************

  task automatic idle_cycles(int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic write_reg(pu_pkg::addr_t addr, logic [DATA_WIDTH-1:0] data);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    idle_cycles($urandom % 5); // Back-pressure on the response.
    bready <= 1'b1;
    do @(posedge clk); while (!bvalid);
    bready <= 1'b0;
  endtask

  task automatic read_reg(pu_pkg::addr_t addr);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    idle_cycles($urandom % 5);
    rready <= 1'b1;
    do @(posedge clk); while (!rvalid);
    rready <= 1'b0;
  endtask

  // Signed value that fits the low half.
  function automatic logic [DATA_WIDTH-1:0] fit_half();
    logic [HALF-1:0] low;
    low = $urandom;
    return {{(DATA_WIDTH-HALF){low[HALF-1]}}, low};
  endfunction

  // **********************************************************************
  // Test sequences.
  // **********************************************************************

  task automatic read_all_results();
    read_reg(pu_pkg::OFF_MULT_A);
    read_reg(pu_pkg::OFF_ADD_A);
    read_reg(pu_pkg::OFF_MULT_ATTR);
    read_reg(pu_pkg::OFF_ADD_ATTR);
  endtask

  task automatic mult_cases();
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    for (int i = 0; i < NUM_MULT; i++) begin
      a = ($urandom % 4 == 0) ? DATA_WIDTH'($urandom) : fit_half();
      b = ($urandom % 4 == 0) ? DATA_WIDTH'($urandom) : fit_half();
      write_reg(pu_pkg::OFF_MULT_A, a);
      write_reg(pu_pkg::OFF_MULT_B, b);
      read_reg(pu_pkg::OFF_MULT_A);
      read_reg(pu_pkg::OFF_MULT_ATTR);
    end
  endtask

  task automatic add_pair(logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b);
    write_reg(pu_pkg::OFF_ADD_A, a);
    write_reg(pu_pkg::OFF_ADD_B, b);
    read_reg(pu_pkg::OFF_ADD_A);
    read_reg(pu_pkg::OFF_ADD_ATTR);
  endtask

  task automatic add_cases();
    logic [DATA_WIDTH-1:0] max_pos;
    logic [DATA_WIDTH-1:0] min_neg;
    max_pos = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    min_neg = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    for (int i = 0; i < NUM_ADD; i++) begin
      add_pair(DATA_WIDTH'($urandom), DATA_WIDTH'($urandom));
    end
    add_pair(max_pos, 1);
    add_pair(min_neg, '1);
    add_pair(max_pos, max_pos);
    add_pair(min_neg, min_neg);
    add_pair(max_pos, min_neg); // Opposite signs never overflow.
  endtask

  task automatic marked_mix();
    pu_pkg::addr_t         mark [0:3];
    logic [DATA_WIDTH-1:0] mult_val [0:1];
    logic [DATA_WIDTH-1:0] add_val [0:1];
    logic                  add_first;
    for (int i = 0; i < NUM_MIX; i++) begin
      for (int k = 0; k < 4; k++) begin
        mark[k] = ($urandom % 3 == 0) ? pu_pkg::MARK_INVALID : 8'h00;
      end
      mult_val[0] = fit_half();
      mult_val[1] = fit_half();
      add_val[0]  = DATA_WIDTH'($urandom);
      add_val[1]  = DATA_WIDTH'($urandom);
      add_first   = $urandom % 2;
      if (add_first) begin
        write_reg(pu_pkg::OFF_ADD_A | mark[2], add_val[0]);
        write_reg(pu_pkg::OFF_MULT_A | mark[0], mult_val[0]);
        write_reg(pu_pkg::OFF_ADD_B | mark[3], add_val[1]);
        write_reg(pu_pkg::OFF_MULT_B | mark[1], mult_val[1]);
      end else begin
        write_reg(pu_pkg::OFF_MULT_A | mark[0], mult_val[0]);
        write_reg(pu_pkg::OFF_ADD_A | mark[2], add_val[0]);
        write_reg(pu_pkg::OFF_MULT_B | mark[1], mult_val[1]);
        write_reg(pu_pkg::OFF_ADD_B | mark[3], add_val[1]);
      end
      read_all_results();
    end
  endtask

  task automatic unmapped_reads();
    pu_pkg::addr_t holes [0:5] = '{8'h04, 8'h0C, 8'h18, 8'h1C, 8'h20, 8'h24};
    for (int i = 0; i < NUM_HOLES; i++) begin
      if (i < 6) begin
        read_reg(holes[i]);
      end else begin
        read_reg(pu_pkg::addr_t'(8'h40 + $urandom % 192));
      end
    end
  endtask

  // **********************************************************************
  // Main sequence and watchdog.
  // **********************************************************************

  initial begin
    void'($urandom(32'hd56c));
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    read_all_results(); // Everything reads zero out of reset.
    mult_cases();
    add_cases();
    marked_mix();
    unmapped_reads();
    idle_cycles(10);

    run_errors = 0;
    if (outstanding != 0) begin
      $display("Run ended with %0d responses still outstanding.", outstanding);
      run_errors = 1;
    end
    $display("Value errors: %0d, protocol errors: %0d, run errors: %0d.",
             value_errors, protocol_errors, run_errors);
    if (value_errors + protocol_errors + run_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + 400 * NUM_TXN) @(posedge clk);
    $display("Run timed out after %0d cycles without finishing the tests.",
             RESET_CYCLES + 400 * NUM_TXN);
    $display("test failed");
    $finish;
  end

endmodule

/* Bender.yml */
package:
  name: pu_coprocessor

sources:
  - design/pu_pkg.sv
  - design/pu_mult.sv
  - design/pu_add.sv
  - design/pu_axil_port.sv
  - design/pu_top.sv
  - target: test
    files:
      - test/pu_checker.sv
      - test/pu_tb.sv

/* project.f */
design/pu_pkg.sv
design/pu_mult.sv
design/pu_add.sv
design/pu_axil_port.sv
design/pu_top.sv
test/pu_checker.sv
test/pu_tb.sv
